//--- compile.f
src/cnode_pkg.sv
src/cnode_rotator.sv
src/cnode_sort_engine.sv
src/cnode_ctx_fifo.sv
src/cnode_restore.sv
src/cnode_top.sv
bench/tb_cnode_assertions.sv
bench/tb_cnode.sv

//--- Bender.yml
package:
  name: cnode

sources:
  - src/cnode_pkg.sv
  - src/cnode_rotator.sv
  - src/cnode_sort_engine.sv
  - src/cnode_ctx_fifo.sv
  - src/cnode_restore.sv
  - src/cnode_top.sv
  - target: test
    files:
      - bench/tb_cnode_assertions.sv
      - bench/tb_cnode.sv

//--- bench/tb_cnode.sv
`timescale 1ns/1ps

module tb_cnode;

  localparam int cROWS    = 10;
  localparam int cFIXED   = 21;                          // beats with hand-picked values
  localparam int cBEATS   = 43;                          // all beats of the run
  localparam int cMAG_MAX = (1 << cnode_pkg::cMAG_W) - 1;

  // DUT side
  logic                            iclk = 1'b0;
  logic                            ireset;
  logic                            istart;
  logic                            inorm_bypass;
  logic                            ival;
  cnode_pkg::strb_t                istrb;
  cnode_pkg::shift_t               ishift;
  cnode_pkg::znode_t               ivnode;
  logic                            ocnode_val;
  logic [cnode_pkg::cADDR_W-1 : 0] ocnode_addr;
  cnode_pkg::znode_t               ocnode;
  logic                            odecfail;
  logic                            obusy;

  // len, bypass, random, extra gap, sync (1 drain+check, 2 then istart), fail (-1 any)
  int row_tab [cROWS][6] = '{
    '{2, 0, 0, 0, 1,  0},   // all positive, min tie in lane 3
    '{2, 1, 0, 0, 0,  0},   // same values without offset
    '{3, 1, 0, 0, 1,  1},   // lane 0 odd
    '{8, 0, 0, 0, 0, -1},   // full row with -32 and 0
    '{5, 0, 0, 0, 0, -1},   // mixed shifts, minimum spacing from here
    '{1, 0, 0, 0, 0, -1},
    '{4, 0, 1, 0, 0, -1},
    '{8, 0, 1, 0, 2, -1},
    '{3, 1, 1, 2, 0, -1},
    '{7, 1, 1, 0, 1, -1}
  };

  // shift per beat, in run order
  int shift_tab [cBEATS] = '{
    0, 0, 0, 0, 0, 0, 0,
    0, 0, 0, 0, 0, 0, 0, 0,
    1, 2, 3, 0, 1, 3,
    2, 1, 0, 3,
    0, 1, 2, 3, 3, 2, 1, 0,
    1, 1, 2,
    3, 0, 2, 1, 1, 0, 3
  };

  // lane 0..3 per beat, fixed rows only
  int val_tab [cFIXED][4] = '{
    '{  5,   7,   9,   3}, '{  4,  10,   2,   3},
    '{  5,   7,   9,   3}, '{  4,  10,   2,   3},
    '{ -3,   6,   8,   1}, '{  2,  -6,  -8,   4}, '{  7,  -5, -12,   9},
    '{-32,  12,   0,  15}, '{ 20, -13,   1, -15}, '{ -1,  25,   2,  14},
    '{ 31,  30,  -3,  13}, '{-17,   4,   4,  12}, '{  8,   3,   5, -11},
    '{  9, -31,   6,  10}, '{ 10,  29,  -7,   9},
    '{ -4,  18,  22,  -9}, '{  6,  -2,  14,   3}, '{ 11,   7, -26,  27},
    '{-16,   5,  19,   1}, '{  2, -21,   8,  30},
    '{-10,   0,  23,  -5}
  };

  int                beat_v  [cnode_pkg::cROW_MAX][cnode_pkg::cZ];  // current row
  int                beat_sh [cnode_pkg::cROW_MAX];
  cnode_pkg::znode_t exp_q   [$];
  cnode_pkg::znode_t exp_beat;
  int                exp_addr = 0;
  bit                exp_fail = 1'b0;
  int                cyc      = 0;
  int                limit;

  cnode_top u_dut (
    .iclk         ( iclk         ),
    .ireset       ( ireset       ),
    .istart       ( istart       ),
    .inorm_bypass ( inorm_bypass ),
    .ival         ( ival         ),
    .istrb        ( istrb        ),
    .ishift       ( ishift       ),
    .ivnode       ( ivnode       ),
    .ocnode_val   ( ocnode_val   ),
    .ocnode_addr  ( ocnode_addr  ),
    .ocnode       ( ocnode       ),
    .odecfail     ( odecfail     ),
    .obusy        ( obusy        )
  );

  always #20 iclk = ~iclk;

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // cycles of every row, worst case spacing and drain
  function automatic int run_limit();
    int sum;
    sum = 50;
    for (int r = 0; r < cROWS; r++) begin
      sum += 2 * row_tab[r][0] + row_tab[r][3] + 10;
    end
    return sum;
  endfunction

  // all expected beats out, then the pipe has to be idle
  task automatic wait_idle();
    while (exp_q.size() != 0) begin
      @(negedge iclk);
    end
    @(negedge iclk);
    check_val("obusy", obusy, 1'b0);
  endtask

  task automatic drive_row(input int len);
    for (int b = 0; b < len; b++) begin
      ival      = 1'b1;
      istrb.sop = (b == 0);
      istrb.eop = (b == len - 1);
      ishift    = beat_sh[b];
      for (int l = 0; l < cnode_pkg::cZ; l++) begin
        ivnode[l] = beat_v[b][l];
      end
      @(negedge iclk);
    end
    ival  = 1'b0;
    istrb = '0;
  endtask

  // reference model, one row
  task automatic push_expected(input int len, input bit byp, output bit row_fail);
    int                rv  [cnode_pkg::cROW_MAX][cnode_pkg::cZ];  // aligned lanes
    int                mag [cnode_pkg::cROW_MAX][cnode_pkg::cZ];
    int                m1  [cnode_pkg::cZ];
    int                m2  [cnode_pkg::cZ];
    int                i1  [cnode_pkg::cZ];
    bit                rs  [cnode_pkg::cZ];
    int                m;
    bit                neg;
    cnode_pkg::znode_t msg;
    cnode_pkg::znode_t outv;
    row_fail = 1'b0;
    for (int b = 0; b < len; b++) begin
      for (int l = 0; l < cnode_pkg::cZ; l++) begin
        rv[b][l]  = beat_v[b][(l + beat_sh[b]) % cnode_pkg::cZ];  // rotate left
        mag[b][l] = (rv[b][l] < 0) ? -rv[b][l] : rv[b][l];
        if (mag[b][l] > cMAG_MAX) begin
          mag[b][l] = cMAG_MAX;  // -32 saturates
        end
      end
    end
    for (int l = 0; l < cnode_pkg::cZ; l++) begin
      m1[l] = cMAG_MAX + 1;
      i1[l] = 0;
      rs[l] = 1'b0;
      for (int b = 0; b < len; b++) begin
        rs[l] = rs[l] ^ (rv[b][l] < 0);
        if (mag[b][l] < m1[l]) begin
          m1[l] = mag[b][l];  // earliest smallest wins
          i1[l] = b;
        end
      end
      m2[l] = cMAG_MAX;  // single beat row keeps this
      for (int b = 0; b < len; b++) begin
        if (b != i1[l] && mag[b][l] < m2[l]) begin
          m2[l] = mag[b][l];
        end
      end
      row_fail = row_fail | rs[l];  // odd lane parity
    end
    for (int b = 0; b < len; b++) begin
      for (int l = 0; l < cnode_pkg::cZ; l++) begin
        m = (b == i1[l]) ? m2[l] : m1[l];
        if (!byp) begin
          m = (m > cnode_pkg::cNORM_OFFSET) ? m - cnode_pkg::cNORM_OFFSET : 0;
        end
        neg    = rs[l] ^ (rv[b][l] < 0);
        msg[l] = cnode_pkg::node_t'(neg ? -m : m);
      end
      for (int l = 0; l < cnode_pkg::cZ; l++) begin
        outv[l] = msg[(l + cnode_pkg::cZ - beat_sh[b]) % cnode_pkg::cZ];  // rotate right
      end
      exp_q.push_back(outv);
    end
  endtask

  // ----------------------------------------
  // monitor and timeout
  // ----------------------------------------

  always @(negedge iclk) begin
    if (!ireset && ocnode_val) begin
      if (exp_q.size() == 0) begin
        $display("output beat at %0t ns arrived with nothing expected", $time);
        stop_run();
      end else begin
        exp_beat = exp_q.pop_front();
        for (int l = 0; l < cnode_pkg::cZ; l++) begin
          check_val($sformatf("ocnode[%0d]", l), ocnode[l], exp_beat[l]);
        end
        check_val("ocnode_addr", ocnode_addr, exp_addr);
        exp_addr++;
      end
    end
  end

  always @(negedge iclk) begin
    if (u_dut.u_assert.fail_cnt != 0) begin
      $display("a concurrent assertion on the DUT failed at %0t ns", $time);
      stop_run();
    end
  end

  always @(posedge iclk) begin
    cyc <= cyc + 1;
    if (cyc > limit) begin
      $display("timeout after %0d cycles with %0d expected beats still missing",
               limit, exp_q.size());
      stop_run();
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin
    int seed;
    int vp;
    int sp;
    int len;
    int last_eop;
    int prev_len;
    int prev_gap;
    bit row_fail;
    limit        = run_limit();
    seed         = $urandom(32'he41e);
    vp           = 0;
    sp           = 0;
    last_eop     = 0;
    prev_len     = 0;
    prev_gap     = 0;
    ireset       = 1'b0;
    istart       = 1'b0;
    inorm_bypass = 1'b0;
    ival         = 1'b0;
    istrb        = '0;
    ishift       = '0;
    ivnode       = '0;
    #5 ireset = 1'b1;
    repeat (2) @(negedge iclk);
    ireset = 1'b0;
    istart = 1'b1;  // clear address and fail flag
    @(negedge iclk);
    istart = 1'b0;

    for (int r = 0; r < cROWS; r++) begin
      len = row_tab[r][0];
      for (int b = 0; b < len; b++) begin
        beat_sh[b] = shift_tab[sp];
        sp++;
        for (int l = 0; l < cnode_pkg::cZ; l++) begin
          if (row_tab[r][2] != 0) begin
            beat_v[b][l] = int'($urandom % 64) - 32;
          end else begin
            beat_v[b][l] = val_tab[vp][l];
          end
        end
        if (row_tab[r][2] == 0) begin
          vp++;
        end
      end
      if (row_tab[r][1] != inorm_bypass) begin
        wait_idle();  // bypass only changes on an empty pipe
      end
      // eop no earlier than previous eop + previous length + 2
      while (cyc + len < last_eop + prev_len + 2 + prev_gap) begin
        @(negedge iclk);
      end
      inorm_bypass = row_tab[r][1];
      push_expected(len, row_tab[r][1], row_fail);
      if (row_tab[r][5] >= 0) begin
        check_val("table fail column", row_fail, row_tab[r][5]);
      end
      exp_fail = exp_fail | row_fail;
      drive_row(len);
      last_eop = cyc;  // edge that sampled eop
      prev_len = len;
      prev_gap = row_tab[r][3];
      if (row_tab[r][4] > 0) begin
        wait_idle();
        check_val("odecfail", odecfail, exp_fail);
        if (row_tab[r][4] == 2) begin
          istart = 1'b1;
          @(negedge iclk);
          istart   = 1'b0;
          exp_fail = 1'b0;
          exp_addr = 0;
          check_val("odecfail", odecfail, 1'b0);
          check_val("ocnode_addr", ocnode_addr, 0);
        end
      end
    end

    wait_idle();
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- bench/tb_cnode_assertions.sv
`timescale 1ns/1ps

module cnode_assertions (
  input logic                            iclk,
  input logic                            ireset,
  input logic                            istart,
  input logic                            ival,
  input cnode_pkg::strb_t                istrb,
  input logic                            ocnode_val,
  input logic [cnode_pkg::cADDR_W-1 : 0] ocnode_addr,
  input logic                            obusy,
  input logic                            fifo_write,
  input logic                            fifo_full,
  input logic                            row_in_flight  // any stage past the sort
);

  int fail_cnt = 0;  // failed assertions so far

  // ----------------------------------------
  // output side
  // ----------------------------------------

  a_reset_quiet : assert property (@(posedge iclk) ireset |-> (!ocnode_val && !obusy))
    else begin
      $error("output valid or busy while in reset");
      fail_cnt++;
    end

  a_addr_step : assert property (@(posedge iclk) disable iff (ireset)
    (ocnode_val && !istart) |=> (ocnode_addr == $past(ocnode_addr) + 1'b1))
    else begin
      $error("output address did not advance by one");
      fail_cnt++;
    end

  a_fifo_ovf : assert property (@(posedge iclk) disable iff (ireset)
    fifo_write |-> !fifo_full)
    else begin
      $error("context fifo written while full");
      fail_cnt++;
    end

  // eop on a quiet pipe, first output 5 ticks later
  a_latency : assert property (@(posedge iclk) disable iff (ireset)
    (ival && istrb.eop && !row_in_flight) |=> !ocnode_val [*5] ##1 ocnode_val)
    else begin
      $error("first output not 5 cycles after eop");
      fail_cnt++;
    end

endmodule

bind cnode_top cnode_assertions u_assert (
  .iclk          ( iclk                                                          ),
  .ireset        ( ireset                                                        ),
  .istart        ( istart                                                        ),
  .ival          ( ival                                                          ),
  .istrb         ( istrb                                                         ),
  .ocnode_val    ( ocnode_val                                                    ),
  .ocnode_addr   ( ocnode_addr                                                   ),
  .obusy         ( obusy                                                         ),
  .fifo_write    ( rot_val                                                       ),
  .fifo_full     ( fifo_full                                                     ),
  .row_in_flight ( sort_done[0] | rst_read | fifo_rval | rst_val | ocnode_val   )
);

//--- src/cnode_top.sv
`timescale 1ns/1ps

module cnode_top (
  input  logic                              iclk,
  input  logic                              ireset,
  input  logic                              istart,
  input  logic                              inorm_bypass,
  input  logic                              ival,
  input  cnode_pkg::strb_t                  istrb,
  input  cnode_pkg::shift_t                 ishift,
  input  cnode_pkg::znode_t                 ivnode,
  output logic                              ocnode_val,
  output logic [cnode_pkg::cADDR_W-1 : 0]   ocnode_addr,
  output cnode_pkg::znode_t                 ocnode,
  output logic                              odecfail,
  output logic                              obusy
);

  // input rotator side
  logic              rot_val;
  cnode_pkg::znode_t rot_dat;
  cnode_pkg::strb_t  strb_d;     // aligned with rotator output
  cnode_pkg::shift_t shift_d;

  // sort engines
  logic              sort_done    [cnode_pkg::cZ];
  cnode_pkg::idx_t   sort_row_len [cnode_pkg::cZ];
  cnode_pkg::mag_t   sort_min1    [cnode_pkg::cZ];
  cnode_pkg::mag_t   sort_min2    [cnode_pkg::cZ];
  cnode_pkg::idx_t   sort_idx     [cnode_pkg::cZ];
  cnode_pkg::zsign_t row_sign;
  logic [cnode_pkg::cZ-1 : 0] parity_err;

  // context fifo
  cnode_pkg::ctx_t   fifo_wdat;
  cnode_pkg::ctx_t   fifo_rdat;
  logic              fifo_rval;
  logic              fifo_empty;
  logic              fifo_full;
  logic              fifo_nempty_q;

  // restore
  logic              rst_read;
  logic              rst_val;
  cnode_pkg::shift_t rst_shift;
  cnode_pkg::znode_t rst_cnode;

  // ----------------------------------------
  // input alignment
  // ----------------------------------------

  cnode_rotator #(
    .p_right ( 1'b0 )
  ) u_in_rot (
    .iclk   ( iclk    ),
    .ireset ( ireset  ),
    .ival   ( ival    ),
    .idat   ( ivnode  ),
    .ishift ( ishift  ),
    .oval   ( rot_val ),
    .odat   ( rot_dat )
  );

  // same 1 tick as the rotator
  always_ff @(posedge iclk) begin
    strb_d  <= istrb;
    shift_d <= ishift;
  end

  // ----------------------------------------
  // sort engines, one per lane
  // ----------------------------------------

  for (genvar g = 0; g < cnode_pkg::cZ; g++) begin : g_sort
    cnode_sort_engine u_sort (
      .iclk        ( iclk            ),
      .ireset      ( ireset          ),
      .ival        ( rot_val         ),
      .istrb       ( strb_d          ),
      .ivnode      ( rot_dat[g]      ),
      .osort_done  ( sort_done[g]    ),
      .omin1       ( sort_min1[g]    ),
      .omin2       ( sort_min2[g]    ),
      .omin1_idx   ( sort_idx[g]     ),
      .osign       ( row_sign[g]     ),
      .oparity_err ( parity_err[g]   ),
      .orow_len    ( sort_row_len[g] )
    );

    assign fifo_wdat.sign[g] = rot_dat[g][cnode_pkg::cNODE_W-1];  // sign bit only
  end

  assign fifo_wdat.shift = shift_d;

  // ----------------------------------------
  // context fifo
  // ----------------------------------------

  cnode_ctx_fifo u_fifo (
    .iclk   ( iclk       ),
    .ireset ( ireset     ),
    .iwrite ( rot_val    ),
    .iwdat  ( fifo_wdat  ),
    .iread  ( rst_read   ),
    .ordat  ( fifo_rdat  ),
    .orval  ( fifo_rval  ),
    .oempty ( fifo_empty ),
    .ofull  ( fifo_full  )
  );

  // ----------------------------------------
  // restore and output de-alignment
  // ----------------------------------------

  // lanes finish together, lane 0 drives the read-out
  cnode_restore u_restore (
    .iclk         ( iclk            ),
    .ireset       ( ireset          ),
    .inorm_bypass ( inorm_bypass    ),
    .istart_row   ( sort_done[0]    ),
    .irow_len     ( sort_row_len[0] ),
    .omin1        ( sort_min1       ),
    .omin2        ( sort_min2       ),
    .imin1_idx    ( sort_idx        ),
    .isign        ( row_sign        ),
    .ictx         ( fifo_rdat       ),
    .ictx_val     ( fifo_rval       ),
    .oread        ( rst_read        ),
    .ocnode_val   ( rst_val         ),
    .ocnode_shift ( rst_shift       ),
    .ocnode       ( rst_cnode       )
  );

  cnode_rotator #(
    .p_right ( 1'b1 )
  ) u_out_rot (
    .iclk   ( iclk       ),
    .ireset ( ireset     ),
    .ival   ( rst_val    ),
    .idat   ( rst_cnode  ),
    .ishift ( rst_shift  ),
    .oval   ( ocnode_val ),
    .odat   ( ocnode     )
  );

  // ----------------------------------------
  // address, fail flag, busy
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ocnode_addr   <= '0;
      odecfail      <= 1'b0;
      fifo_nempty_q <= 1'b0;
    end else begin
      ocnode_addr   <= istart ? '0 : (ocnode_addr + ocnode_val);
      fifo_nempty_q <= !fifo_empty;
      if (istart) begin
        odecfail <= 1'b0;
      end else if (sort_done[0] & (|parity_err)) begin
        odecfail <= 1'b1;  // sticky until next run
      end
    end
  end

  // output stream may have holes, so look at fifo too
  assign obusy = ocnode_val | fifo_nempty_q;

endmodule

//--- src/cnode_restore.sv
`timescale 1ns/1ps

module cnode_restore (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              inorm_bypass,
  input  logic              istart_row,
  input  cnode_pkg::idx_t   irow_len,
  input  cnode_pkg::mag_t   omin1     [cnode_pkg::cZ],
  input  cnode_pkg::mag_t   omin2     [cnode_pkg::cZ],
  input  cnode_pkg::idx_t   imin1_idx [cnode_pkg::cZ],
  input  cnode_pkg::zsign_t isign,
  input  cnode_pkg::ctx_t   ictx,
  input  logic              ictx_val,
  output logic              oread,
  output logic              ocnode_val,
  output cnode_pkg::shift_t ocnode_shift,
  output cnode_pkg::znode_t ocnode
);

  cnode_pkg::idx_t   cnt;      // index of read being issued
  cnode_pkg::idx_t   len_q;    // last index of row
  cnode_pkg::idx_t   rd_idx;   // index of context now returning

  cnode_pkg::mag_t   mag_sel [cnode_pkg::cZ];
  cnode_pkg::mag_t   mag_nrm [cnode_pkg::cZ];
  cnode_pkg::node_t  mag_ext [cnode_pkg::cZ];
  cnode_pkg::znode_t msg;

  // ----------------------------------------
  // read-out sequencer
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oread <= 1'b0;
      cnt   <= '0;
      len_q <= '0;
    end else if (istart_row) begin
      oread <= 1'b1;
      cnt   <= '0;
      len_q <= irow_len;
    end else if (oread) begin
      if (cnt == len_q) begin
        oread <= 1'b0;   // whole row issued
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // fifo answers one tick later, index follows it
  always_ff @(posedge iclk) begin
    if (oread) begin
      rd_idx <= cnt;
    end
  end

  // ----------------------------------------
  // per-lane message rebuild
  // ----------------------------------------

  always_comb begin
    for (int l = 0; l < cnode_pkg::cZ; l++) begin
      // exclude own contribution
      mag_sel[l] = (rd_idx == imin1_idx[l]) ? omin2[l] : omin1[l];
      if (inorm_bypass) begin
        mag_nrm[l] = mag_sel[l];
      end else if (mag_sel[l] > cnode_pkg::mag_t'(cnode_pkg::cNORM_OFFSET)) begin
        mag_nrm[l] = mag_sel[l] - cnode_pkg::mag_t'(cnode_pkg::cNORM_OFFSET);
      end else begin
        mag_nrm[l] = '0;  // floor at zero
      end
      mag_ext[l] = cnode_pkg::node_t'({1'b0, mag_nrm[l]});
      // row product without this beat's sign
      msg[l]     = (isign[l] ^ ictx.sign[l]) ? -mag_ext[l] : mag_ext[l];
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ocnode_val <= 1'b0;
    end else begin
      ocnode_val <= ictx_val;
    end
  end

  always_ff @(posedge iclk) begin
    if (ictx_val) begin
      ocnode       <= msg;
      ocnode_shift <= ictx.shift;  // for the output rotator
    end
  end

endmodule

//--- src/cnode_ctx_fifo.sv
`timescale 1ns/1ps

module cnode_ctx_fifo (
  input  logic            iclk,
  input  logic            ireset,
  input  logic            iwrite,
  input  cnode_pkg::ctx_t iwdat,
  input  logic            iread,
  output cnode_pkg::ctx_t ordat,
  output logic            orval,
  output logic            oempty,
  output logic            ofull
);

  cnode_pkg::ctx_t mem [cnode_pkg::cFIFO_DEPTH];

  // extra msb tells full from empty
  logic [cnode_pkg::cFIFO_AW : 0] wptr;
  logic [cnode_pkg::cFIFO_AW : 0] rptr;

  logic wr_ok;
  logic rd_ok;

  // ----------------------------------------
  // flags
  // ----------------------------------------

  assign oempty = (wptr == rptr);
  assign ofull  = (wptr[cnode_pkg::cFIFO_AW] != rptr[cnode_pkg::cFIFO_AW]) &&
                  (wptr[cnode_pkg::cFIFO_AW-1 : 0] == rptr[cnode_pkg::cFIFO_AW-1 : 0]);

  assign wr_ok = iwrite & !ofull;   // drop on overflow
  assign rd_ok = iread  & !oempty;

  // ----------------------------------------
  // pointers
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wptr  <= '0;
      rptr  <= '0;
      orval <= 1'b0;
    end else begin
      orval <= rd_ok;               // data on next tick
      if (wr_ok) begin
        wptr <= wptr + 1'b1;
      end
      if (rd_ok) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // storage
  // ----------------------------------------

  always_ff @(posedge iclk) begin
    if (wr_ok) begin
      mem[wptr[cnode_pkg::cFIFO_AW-1 : 0]] <= iwdat;
    end
    if (rd_ok) begin
      ordat <= mem[rptr[cnode_pkg::cFIFO_AW-1 : 0]];
    end
  end

endmodule

//--- src/cnode_sort_engine.sv
`timescale 1ns/1ps

module cnode_sort_engine (
  input  logic             iclk,
  input  logic             ireset,
  input  logic             ival,
  input  cnode_pkg::strb_t istrb,
  input  cnode_pkg::node_t ivnode,
  output logic             osort_done,
  output cnode_pkg::mag_t  omin1,
  output cnode_pkg::mag_t  omin2,
  output cnode_pkg::idx_t  omin1_idx,
  output logic             osign,
  output logic             oparity_err,
  output cnode_pkg::idx_t  orow_len
);

  // input decode
  logic             vn_sign;
  cnode_pkg::node_t vn_abs;
  cnode_pkg::mag_t  vn_mag;

  // running search state
  cnode_pkg::idx_t  cnt;      // index of next beat
  cnode_pkg::idx_t  cur_idx;
  cnode_pkg::mag_t  min1;
  cnode_pkg::mag_t  min2;
  cnode_pkg::idx_t  min1_idx;
  logic             sign;

  // next state
  cnode_pkg::mag_t  min1_n;
  cnode_pkg::mag_t  min2_n;
  cnode_pkg::idx_t  min1_idx_n;
  logic             sign_n;

  // ----------------------------------------
  // magnitude with saturation
  // ----------------------------------------

  assign vn_sign = ivnode[cnode_pkg::cNODE_W-1];
  assign vn_abs  = vn_sign ? -ivnode : ivnode;
  // only -32 keeps its msb after negation -> clamp to 31
  assign vn_mag  = vn_abs[cnode_pkg::cNODE_W-1] ? '1 : vn_abs[cnode_pkg::cMAG_W-1 : 0];

  // ----------------------------------------
  // min1/min2 search
  // ----------------------------------------

  always_comb begin
    cur_idx = istrb.sop ? '0 : cnt;
    if (istrb.sop) begin
      // new row, restart from this beat
      min1_n     = vn_mag;
      min2_n     = '1;           // no second candidate yet
      min1_idx_n = cur_idx;
      sign_n     = vn_sign;
    end else begin
      min1_n     = min1;
      min2_n     = min2;
      min1_idx_n = min1_idx;
      sign_n     = sign ^ vn_sign;
      if (vn_mag < min1) begin
        min2_n     = min1;       // old min1 drops to second place
        min1_n     = vn_mag;
        min1_idx_n = cur_idx;
      end else if (vn_mag < min2) begin
        min2_n     = vn_mag;     // ties with min1 land here
      end
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cnt        <= '0;
      osort_done <= 1'b0;
    end else begin
      osort_done <= ival & istrb.eop;
      if (ival) begin
        cnt <= cur_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (ival) begin
      min1     <= min1_n;
      min2     <= min2_n;
      min1_idx <= min1_idx_n;
      sign     <= sign_n;
    end
  end

  // ----------------------------------------
  // hold register, stable through read-out
  // ----------------------------------------

  always_ff @(posedge iclk) begin
    if (ival & istrb.eop) begin
      omin1     <= min1_n;
      omin2     <= min2_n;
      omin1_idx <= min1_idx_n;
      osign     <= sign_n;
      orow_len  <= cur_idx;    // beats - 1
    end
  end

  // negative message is a hard one, so sign product is the check parity
  assign oparity_err = osign;

endmodule

//--- src/cnode_rotator.sv
`timescale 1ns/1ps

module cnode_rotator #(
  parameter bit p_right = 1'b0  // 0 : left (align), 1 : right (undo)
) (
  input  logic              iclk,
  input  logic              ireset,
  input  logic              ival,
  input  cnode_pkg::znode_t idat,
  input  cnode_pkg::shift_t ishift,
  output logic              oval,
  output cnode_pkg::znode_t odat
);

  cnode_pkg::znode_t rot;  // combinational rotation result

  // ----------------------------------------
  // lane permutation
  // ----------------------------------------

  // left  : out lane l takes in lane (l + shift) mod cZ
  // right : out lane l takes in lane (l - shift) mod cZ
  always_comb begin
    for (int l = 0; l < cnode_pkg::cZ; l++) begin
      if (p_right) begin
        rot[l] = idat[(l + cnode_pkg::cZ - int'(ishift)) % cnode_pkg::cZ];
      end else begin
        rot[l] = idat[(l + int'(ishift)) % cnode_pkg::cZ];
      end
    end
  end

  // ----------------------------------------
  // output register, 1 tick
  // ----------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else begin
      oval <= ival;
    end
  end

  always_ff @(posedge iclk) begin
    if (ival) begin
      odat <= rot;  // data held between beats
    end
  end

endmodule

//--- src/cnode_pkg.sv
package cnode_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------

  localparam int cZ           = 4;                   // lanes per beat
  localparam int cSHIFT_W     = 2;                   // cyclic shift amount
  localparam int cNODE_W      = 6;                   // signed message, 2's compl
  localparam int cMAG_W       = cNODE_W - 1;         // saturated magnitude
  localparam int cROW_MAX     = 8;                   // beats per row, max
  localparam int cIDX_W       = $clog2(cROW_MAX);    // beat index
  localparam int cNORM_OFFSET = 1;                   // offset min-sum correction
  localparam int cFIFO_DEPTH  = 16;                  // two full rows of context
  localparam int cFIFO_AW     = $clog2(cFIFO_DEPTH);
  localparam int cADDR_W      = 8;                   // output beat address

  // ----------------------------------------
  // types
  // ----------------------------------------

  typedef logic signed [cNODE_W-1 : 0] node_t;
  typedef node_t       [cZ-1 : 0]      znode_t;     // one message per lane

  typedef logic [cMAG_W-1   : 0] mag_t;
  typedef logic [cIDX_W-1   : 0] idx_t;
  typedef logic [cSHIFT_W-1 : 0] shift_t;

  // row framing
  typedef struct packed {
    logic sop;  // first beat of row
    logic eop;  // last beat of row
  } strb_t;

  typedef logic [cZ-1 : 0] zsign_t;  // bit l is lane l

  // context kept per beat until the row is restored
  typedef struct packed {
    zsign_t sign;
    shift_t shift;
  } ctx_t;

endpackage
